// File: all.f
+incdir+verilog
+incdir+test
verilog/freelist_pkg.sv
verilog/freelist_if.sv
verilog/prf_fifo.sv
verilog/checkpoint_bank.sv
verilog/freelist_checkpoint.sv
verilog/rename_freelist_top.sv
test/freelist_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the free list testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module freelist_tb -o freelist_sim

status=0
out=$(./obj_dir/freelist_sim) || status=$?
echo "$out"

if [ "$status" -eq 0 ] && grep -qx "Test OK" <<< "$out"; then
    exit 0
fi
exit 1

// File: test/freelist_tb_model.svh
/* Reference model of the free list, included inside the testbench module.
   Releases are drawn from m_in_use so the pool can never overflow. */

`ifndef FREELIST_TB_MODEL_SVH
`define FREELIST_TB_MODEL_SVH

// Free pool, and registers holding architectural or committed state
prf_t        m_pool[$];
prf_t        m_in_use[$];

// Checkpoint banks as flags, owner and a small entry array
logic        m_valid [`BANK_COUNT];
logic        m_aband [`BANK_COUNT];
fgr_t        m_owner [`BANK_COUNT];
prf_t        m_entry [`BANK_COUNT][`BANK_DEPTH];
int          m_fill  [`BANK_COUNT];
logic [31:0] lfsr;

function automatic void model_reset();
    m_pool.delete();
    m_in_use.delete();
    for (int i = 0; i < `PRF_COUNT; i++) begin
        if (i < `ARCH_COUNT) begin
            m_in_use.push_back(prf_t'(i));
        end else begin
            m_pool.push_back(prf_t'(i));
        end
    end
    for (int b = 0; b < `BANK_COUNT; b++) begin
        m_valid[b] = 1'b0;
        m_aband[b] = 1'b0;
        m_owner[b] = '0;
        m_fill[b]  = 0;
    end
endfunction

// Lowest owner bank with room, else lowest free bank, else -1
function automatic int model_pick(input fgr_t fgr);
    int pick;
    pick = -1;
    for (int b = `BANK_COUNT - 1; b >= 0; b--) begin
        if (!m_valid[b] && !m_aband[b]) begin
            pick = b;
        end
    end
    for (int b = `BANK_COUNT - 1; b >= 0; b--) begin
        if (m_valid[b] && m_owner[b] == fgr && m_fill[b] < `BANK_DEPTH) begin
            pick = b;
        end
    end
    return pick;
endfunction

function automatic logic model_ready(input logic valid, input fgr_t fgr);
    return valid && (m_pool.size() > 0) && (model_pick(fgr) >= 0);
endfunction

function automatic logic model_recovering();
    logic any;
    any = 1'b0;
    for (int b = 0; b < `BANK_COUNT; b++) begin
        any = any | m_aband[b];
    end
    return any;
endfunction

// State change at one rising edge, hits taken from the state before it
function automatic void model_step(input logic av, input fgr_t af, input logic cv,
                                   input fgr_t cf, input logic bv, input fgr_t bf,
                                   input logic rv, input prf_t rprf);
    logic [`BANK_COUNT - 1:0] commit_hit;
    logic [`BANK_COUNT - 1:0] abandon_hit;
    int   pick;
    int   wb;
    prf_t p;
    wb = -1;
    for (int b = `BANK_COUNT - 1; b >= 0; b--) begin
        commit_hit[b]  = cv && m_valid[b] && (m_owner[b] == cf);
        abandon_hit[b] = bv && m_valid[b] && (m_owner[b] == bf);
        if (m_aband[b]) begin
            wb = b;
        end
    end
    pick = model_ready(av, af) ? model_pick(af) : -1;
    if (pick >= 0) begin
        p = m_pool.pop_front();
        if (!m_valid[pick]) begin
            m_valid[pick] = 1'b1;
            m_owner[pick] = af;
        end
        m_entry[pick][m_fill[pick]] = p;
        m_fill[pick]++;
    end
    // Writeback yields the pool tail to a release
    if (rv) begin
        m_pool.push_back(rprf);
    end else if (wb >= 0) begin
        m_pool.push_back(m_entry[wb][0]);
        for (int i = 1; i < `BANK_DEPTH; i++) begin
            m_entry[wb][i - 1] = m_entry[wb][i];
        end
        m_fill[wb]--;
        m_aband[wb] = (m_fill[wb] != 0);
    end
    for (int b = 0; b < `BANK_COUNT; b++) begin
        if (commit_hit[b]) begin
            for (int i = 0; i < m_fill[b]; i++) begin
                m_in_use.push_back(m_entry[b][i]);
            end
            m_fill[b]  = 0;
            m_valid[b] = 1'b0;
            m_aband[b] = 1'b0;
        end else if (abandon_hit[b]) begin
            m_valid[b] = 1'b0;
            m_aband[b] = 1'b1;
        end
    end
endfunction

// Galois LFSR for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
endfunction

// One LFSR step per bit taken
function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
        r = (r << 1) | int'(lfsr[0]);
        lfsr = lfsr_step(lfsr);
    end
    return r;
endfunction

`endif

// File: test/freelist_tb.sv
/* Testbench for the rename free list. Outputs are compared at the falling edge
   against the included model; o_alloc_prf is checked whenever the pool holds one. */

`include "freelist_params.svh"

module freelist_tb;
    import freelist_pkg::*;

    localparam int RANDOM_CYCLES   = 2000;
    // Random phase twice over, leaves room for the directed part
    localparam int WATCHDOG_CYCLES = 2 * RANDOM_CYCLES;

    logic clk;
    logic i_rst_n;
    logic i_alloc_valid;
    fgr_t i_alloc_fgr;
    logic i_commit_valid;
    fgr_t i_commit_fgr;
    logic i_abandon_valid;
    fgr_t i_abandon_fgr;
    logic i_release_valid;
    prf_t i_release_prf;
    logic o_alloc_ready;
    prf_t o_alloc_prf;
    logic o_recovering;
    int   checks;
    int   errors;

    `include "freelist_tb_model.svh"

    rename_freelist_top UUT (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_alloc_valid   (i_alloc_valid),
        .i_alloc_fgr     (i_alloc_fgr),
        .o_alloc_ready   (o_alloc_ready),
        .o_alloc_prf     (o_alloc_prf),
        .i_commit_valid  (i_commit_valid),
        .i_commit_fgr    (i_commit_fgr),
        .i_abandon_valid (i_abandon_valid),
        .i_abandon_fgr   (i_abandon_fgr),
        .i_release_valid (i_release_valid),
        .i_release_prf   (i_release_prf),
        .o_recovering    (o_recovering)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Inputs for one cycle; a release hands back the oldest in-use PRF
    task automatic drive(input logic av, input fgr_t af, input logic cv, input fgr_t cf,
                         input logic bv, input fgr_t bf, input logic rv);
        @(posedge clk);
        i_alloc_valid   <= av;
        i_alloc_fgr     <= af;
        i_commit_valid  <= cv;
        i_commit_fgr    <= cf;
        i_abandon_valid <= bv;
        i_abandon_fgr   <= bf;
        i_release_valid <= rv && (m_in_use.size() > 0);
        if (rv && m_in_use.size() > 0) begin
            i_release_prf <= m_in_use.pop_front();
        end
    endtask

    task automatic alloc_burst(input fgr_t fgr, input int n);
        repeat (n) drive(1'b1, fgr, 1'b0, 3'd0, 1'b0, 3'd0, 1'b0);
    endtask

    task automatic commit_fgr(input fgr_t fgr);
        drive(1'b0, 3'd0, 1'b1, fgr, 1'b0, 3'd0, 1'b0);
    endtask

    task automatic release_burst(input int n);
        repeat (n) drive(1'b0, 3'd0, 1'b0, 3'd0, 1'b0, 3'd0, 1'b1);
    endtask

    // Idle until every abandoned bank has drained
    task automatic wait_recovery();
        drive(1'b0, 3'd0, 1'b0, 3'd0, 1'b0, 3'd0, 1'b0);
        @(negedge clk);
        while (o_recovering) @(negedge clk);
    endtask

    task automatic random_cycle();
        logic av;
        logic cv;
        logic bv;
        logic rv;
        fgr_t af;
        fgr_t cf;
        fgr_t bf;
        av = (rand_bits(2) != 0);
        af = fgr_t'(rand_bits(3));
        cv = (rand_bits(3) == 0);
        cf = fgr_t'(rand_bits(3));
        bv = (rand_bits(3) == 0);
        bf = fgr_t'(rand_bits(3));
        rv = (rand_bits(2) == 0);
        // Same FGR never committed and abandoned together
        if (cv && bv && cf == bf) begin
            bv = 1'b0;
        end
        drive(av, af, cv, cf, bv, bf, rv);
    endtask

    always @(negedge clk) begin : compare
        logic exp_ready;
        logic exp_rec;
        if (i_rst_n !== 1'b1) begin
            model_reset();
        end else begin
            exp_ready = model_ready(i_alloc_valid, i_alloc_fgr);
            exp_rec   = model_recovering();
            checks++;
            if (o_alloc_ready !== exp_ready) begin
                errors++;
                $display("FAIL t=%0t o_alloc_ready got %b expected %b",
                         $time, o_alloc_ready, exp_ready);
            end
            if (m_pool.size() > 0) begin
                if (o_alloc_prf !== m_pool[0]) begin
                    errors++;
                    $display("FAIL t=%0t o_alloc_prf got %0d expected %0d",
                             $time, o_alloc_prf, m_pool[0]);
                end
            end
            if (o_recovering !== exp_rec) begin
                errors++;
                $display("FAIL t=%0t o_recovering got %b expected %b",
                         $time, o_recovering, exp_rec);
            end
            model_step(i_alloc_valid, i_alloc_fgr, i_commit_valid, i_commit_fgr,
                       i_abandon_valid, i_abandon_fgr, i_release_valid, i_release_prf);
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles without a result", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        lfsr            = 32'hbe20_0b7f;
        checks          = 0;
        errors          = 0;
        i_rst_n         = 1'b0;
        i_alloc_valid   = 1'b0;
        i_alloc_fgr     = '0;
        i_commit_valid  = 1'b0;
        i_commit_fgr    = '0;
        i_abandon_valid = 1'b0;
        i_abandon_fgr   = '0;
        i_release_valid = 1'b0;
        i_release_prf   = '0;
        repeat (3) @(posedge clk);
        i_rst_n <= 1'b1;

        // In-order allocation spilling into a second bank, then commit
        alloc_burst(3'd1, 8);
        commit_fgr(3'd1);
        // Four owners fill every bank, a fifth waits on a commit
        for (int g = 4; g < 8; g++) begin
            alloc_burst(fgr_t'(g), 4);
        end
        drive(1'b1, 3'd0, 1'b1, 3'd5, 1'b0, 3'd0, 1'b0);
        alloc_burst(3'd0, 1);
        commit_fgr(3'd0);
        commit_fgr(3'd4);
        commit_fgr(3'd6);
        commit_fgr(3'd7);
        // Pool runs dry, last two requests see no ready
        alloc_burst(3'd1, 9);
        commit_fgr(3'd1);
        // Abandon writes back in bank then FIFO order, drained afterwards
        release_burst(8);
        alloc_burst(3'd2, 6);
        drive(1'b0, 3'd0, 1'b0, 3'd0, 1'b1, 3'd2, 1'b0);
        wait_recovery();
        alloc_burst(3'd3, 8);
        commit_fgr(3'd3);
        // Releases ahead of writeback
        release_burst(4);
        alloc_burst(3'd1, 4);
        drive(1'b0, 3'd0, 1'b0, 3'd0, 1'b1, 3'd1, 1'b1);
        release_burst(2);
        wait_recovery();
        alloc_burst(3'd5, 7);
        commit_fgr(3'd5);

        repeat (RANDOM_CYCLES) random_cycle();
        drive(1'b0, 3'd0, 1'b0, 3'd0, 1'b0, 3'd0, 1'b0);
        repeat (2) @(posedge clk);

        $display("Cycles checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/checkpoint_bank.sv
/* One checkpoint bank recording up to BANK_DEPTH PRFs of its owner FGR.
   Pushes and pops never meet in one cycle, since only abandoned banks pop. */

`include "freelist_params.svh"

module checkpoint_bank (
    input  logic    clk,
    input  logic    i_rst_n,
    bank_if.bank    bank
);
    import freelist_pkg::*;

    localparam int FILL_W = $clog2(`BANK_DEPTH + 1);

    bank_state_t         state;
    logic [FILL_W - 1:0] fill;
    logic                last_pop;

    prf_fifo #(
        .DEPTH          (`BANK_DEPTH)
    ) u_fifo (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_push         (bank.alloc),
        .i_push_prf     (bank.prf_in),
        .i_pop          (bank.pop),
        .i_clear        (bank.clear),
        .o_head_prf     (bank.prf_out),
        .o_full         (bank.full),
        .o_empty        (bank.empty)
    );

    // Entry count so the final writeback can free the bank on its own edge
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fill <= '0;
        end else if (bank.clear) begin
            fill <= '0;
        end else if (bank.alloc) begin
            fill <= fill + 1'b1;
        end else if (bank.pop) begin
            fill <= fill - 1'b1;
        end
    end

    assign last_pop = bank.pop && (fill == FILL_W'(1));

    // Tag flags and owner
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= '0;
        end else if (bank.clear) begin
            state <= '0;
        end else begin
            if (bank.alloc && !state.valid) begin
                state.valid <= 1'b1;
                state.owner <= bank.fgr_in;
            end
            // An allocation landing on the abandon edge is still written back
            if (bank.abandon) begin
                state.valid     <= 1'b0;
                state.abandoned <= 1'b1;
            end else if (state.abandoned && last_pop) begin
                state.abandoned <= 1'b0;
            end
        end
    end

    assign bank.state = state;

    a_no_alloc_abandoned: assert property (@(posedge clk) disable iff (!i_rst_n)
        bank.alloc |-> !state.abandoned);

    // An abandoned bank always has something left to return
    a_abandoned_holds: assert property (@(posedge clk) disable iff (!i_rst_n)
        state.abandoned |-> !bank.empty);

endmodule

// File: verilog/freelist_checkpoint.sv
/* Checkpoint array. Commit and abandon of the same FGR in one cycle is undefined.
   Every valid bank owning a committed or abandoned FGR is hit at once. */

`include "freelist_params.svh"

module freelist_checkpoint (
    input  logic                clk,
    input  logic                i_rst_n,

    acq_if.dst                  acq,

    input  logic                i_abandon_valid,
    input  freelist_pkg::fgr_t  i_abandon_fgr,

    input  logic                i_commit_valid,
    input  freelist_pkg::fgr_t  i_commit_fgr,

    output logic                o_wb_valid,
    input  logic                i_wb_ready,
    output freelist_pkg::prf_t  o_wb_prf
);
    import freelist_pkg::*;

    localparam int BC = `BANK_COUNT;

    logic [BC - 1:0] own_hit;
    logic [BC - 1:0] free_hit;
    logic [BC - 1:0] alloc_cand;
    logic [BC - 1:0] alloc_sel;
    logic [BC - 1:0] commit_hit;
    logic [BC - 1:0] abandon_hit;
    logic [BC - 1:0] abandoned;
    logic [BC - 1:0] wb_sel;
    prf_t            wb_head [BC];

    // Keeps only the lowest set bit
    function automatic logic [BC - 1:0] lowest(input logic [BC - 1:0] v);
        return v & (~v + 1'b1);
    endfunction

    for (genvar i = 0; i < BC; i++) begin : g_bank
        bank_if bif ();

        checkpoint_bank u_bank (
            .clk        (clk),
            .i_rst_n    (i_rst_n),
            .bank       (bif.bank)
        );

        // Candidates for the incoming allocation
        assign own_hit[i]  = bif.state.valid & ~bif.full & (bif.state.owner == acq.fgr);
        assign free_hit[i] = ~bif.state.valid & ~bif.state.abandoned;

        // Commit and abandon only match banks still speculating
        assign commit_hit[i]  = bif.state.valid & i_commit_valid
                              & (bif.state.owner == i_commit_fgr);
        assign abandon_hit[i] = bif.state.valid & i_abandon_valid
                              & (bif.state.owner == i_abandon_fgr);

        assign abandoned[i] = bif.state.abandoned;

        assign bif.alloc   = alloc_sel[i];
        assign bif.pop     = wb_sel[i] & i_wb_ready;
        assign bif.clear   = commit_hit[i];
        assign bif.abandon = abandon_hit[i];
        assign bif.prf_in  = acq.prf;
        assign bif.fgr_in  = acq.fgr;

        assign wb_head[i] = wb_sel[i] ? bif.prf_out : '0;
    end

    // Owner with room first, then the lowest free bank
    always_comb begin
        if (|own_hit) begin
            alloc_cand = lowest(own_hit);
        end else begin
            alloc_cand = lowest(free_hit);
        end
    end

    assign alloc_sel = alloc_cand & {BC{acq.valid}};
    assign acq.ready = |alloc_sel;

    // Writeback drains banks in index order
    assign wb_sel     = lowest(abandoned);
    assign o_wb_valid = |abandoned;

    always_comb begin
        o_wb_prf = '0;
        for (int i = 0; i < BC; i++) begin
            o_wb_prf = o_wb_prf | wb_head[i];
        end
    end

    a_commit_abandon_clash: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_commit_valid && i_abandon_valid && (i_commit_fgr == i_abandon_fgr)));

endmodule

// File: verilog/freelist_if.sv
/* Internal channels of the free list. A transfer on acq_if happens on a rising
   edge with valid and ready both high; bank_if carries one bank's controls. */

// Allocation handed from the free pool to the checkpoint array
interface acq_if;
    import freelist_pkg::*;

    logic   valid;
    logic   ready;
    fgr_t   fgr;
    prf_t   prf;

    modport src (
        output valid, fgr, prf,
        input  ready
    );

    modport dst (
        input  valid, fgr, prf,
        output ready
    );
endinterface

// Controls and status of a single checkpoint bank
interface bank_if;
    import freelist_pkg::*;

    logic           alloc;
    logic           pop;
    logic           clear;
    logic           abandon;
    prf_t           prf_in;
    fgr_t           fgr_in;

    bank_state_t    state;
    prf_t           prf_out;
    logic           full;
    logic           empty;

    modport ctrl (
        output alloc, pop, clear, abandon, prf_in, fgr_in,
        input  state, prf_out, full, empty
    );

    modport bank (
        input  alloc, pop, clear, abandon, prf_in, fgr_in,
        output state, prf_out, full, empty
    );
endinterface

// File: verilog/freelist_params.svh
/* Sizing of the rename free list and its checkpoints.
   PRF_COUNT and BANK_DEPTH must be powers of two. */

`ifndef FREELIST_PARAMS_SVH
`define FREELIST_PARAMS_SVH

// Physical register and speculation group widths
`define PRF_WIDTH   6
`define FGR_WIDTH   3

// Register file population
`define PRF_COUNT   64
`define ARCH_COUNT  32

// Checkpoint array shape
`define BANK_COUNT  4
`define BANK_DEPTH  4

`endif

// File: verilog/freelist_pkg.sv
/* Types shared by the free list, the checkpoint banks and their interfaces */

`include "freelist_params.svh"

package freelist_pkg;

    // Physical register number
    typedef logic [`PRF_WIDTH - 1:0] prf_t;

    // Speculation group tag
    typedef logic [`FGR_WIDTH - 1:0] fgr_t;

    // Bookkeeping of one checkpoint bank
    // A bank is free when neither flag is set
    typedef struct packed {
        logic   valid;
        logic   abandoned;
        fgr_t   owner;
    } bank_state_t;

endpackage

// File: verilog/prf_fifo.sv
/* Circular PRF FIFO, DEPTH a power of two of at least 2. Reset may preload
   PRELOAD_COUNT consecutive numbers from PRELOAD_BASE; clear wins over push. */

module prf_fifo #(
    parameter int DEPTH         = 4,
    parameter int PRELOAD_BASE  = 0,
    parameter int PRELOAD_COUNT = 0
) (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_push,
    input  freelist_pkg::prf_t  i_push_prf,
    input  logic                i_pop,
    input  logic                i_clear,
    output freelist_pkg::prf_t  o_head_prf,
    output logic                o_full,
    output logic                o_empty
);
    import freelist_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    prf_t               mem [DEPTH];
    logic [PTR_W - 1:0] rd_ptr;
    logic [PTR_W - 1:0] wr_ptr;
    logic [CNT_W - 1:0] count;

    // Pointers and occupancy
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= PTR_W'(PRELOAD_COUNT);
            count  <= CNT_W'(PRELOAD_COUNT);
        end else if (i_clear) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage, filled with consecutive PRFs on reset when preloading
    if (PRELOAD_COUNT > 0) begin : g_preload
        always_ff @(posedge clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                for (int i = 0; i < DEPTH; i++) begin
                    mem[i] <= (i < PRELOAD_COUNT) ? prf_t'(PRELOAD_BASE + i) : '0;
                end
            end else if (i_push) begin
                mem[wr_ptr] <= i_push_prf;
            end
        end
    end else begin : g_plain
        always_ff @(posedge clk) begin
            if (i_push) begin
                mem[wr_ptr] <= i_push_prf;
            end
        end
    end

    assign o_head_prf = mem[rd_ptr];
    assign o_full     = (count == CNT_W'(DEPTH));
    assign o_empty    = (count == '0);

    a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_push && !i_clear |-> !o_full || i_pop);

    a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_pop && !i_clear |-> !o_empty);

endmodule

// File: verilog/rename_freelist_top.sv
/* Physical register free list with FGR checkpoints. Releases have no back-pressure
   and take the pool push port ahead of abandon writeback. */

`include "freelist_params.svh"

module rename_freelist_top (
    input  logic                clk,
    input  logic                i_rst_n,

    input  logic                i_alloc_valid,
    input  freelist_pkg::fgr_t  i_alloc_fgr,
    output logic                o_alloc_ready,
    output freelist_pkg::prf_t  o_alloc_prf,

    input  logic                i_commit_valid,
    input  freelist_pkg::fgr_t  i_commit_fgr,

    input  logic                i_abandon_valid,
    input  freelist_pkg::fgr_t  i_abandon_fgr,

    input  logic                i_release_valid,
    input  freelist_pkg::prf_t  i_release_prf,

    output logic                o_recovering
);
    import freelist_pkg::*;

    prf_t   pool_head;
    logic   pool_empty;
    logic   pool_push;
    logic   pool_pop;
    prf_t   pool_push_prf;

    logic   wb_valid;
    logic   wb_ready;
    prf_t   wb_prf;

    acq_if acq ();

    // Free pool starts with every non-architectural register
    prf_fifo #(
        .DEPTH          (`PRF_COUNT),
        .PRELOAD_BASE   (`ARCH_COUNT),
        .PRELOAD_COUNT  (`PRF_COUNT - `ARCH_COUNT)
    ) u_pool (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_push         (pool_push),
        .i_push_prf     (pool_push_prf),
        .i_pop          (pool_pop),
        .i_clear        (1'b0),
        .o_head_prf     (pool_head),
        .o_full         (),
        .o_empty        (pool_empty)
    );

    freelist_checkpoint u_checkpoint (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .acq                (acq.dst),
        .i_abandon_valid    (i_abandon_valid),
        .i_abandon_fgr      (i_abandon_fgr),
        .i_commit_valid     (i_commit_valid),
        .i_commit_fgr       (i_commit_fgr),
        .o_wb_valid         (wb_valid),
        .i_wb_ready         (wb_ready),
        .o_wb_prf           (wb_prf)
    );

    // Allocation offered only while the pool has a register
    assign acq.valid = i_alloc_valid & ~pool_empty;
    assign acq.fgr   = i_alloc_fgr;
    assign acq.prf   = pool_head;

    assign pool_pop      = acq.valid & acq.ready;
    assign o_alloc_ready = acq.ready;
    assign o_alloc_prf   = pool_head;

    // Release owns the push port, writeback waits
    assign wb_ready      = ~i_release_valid;
    assign pool_push     = i_release_valid | (wb_valid & wb_ready);
    assign pool_push_prf = i_release_valid ? i_release_prf : wb_prf;

    assign o_recovering = wb_valid;

endmodule
